/* hdl/boot_pkg.sv */
// Boot memory subsystem definitions
package boot_pkg;

  localparam int ADDR_WIDTH = 28;
  localparam int DATA_WIDTH = 64;

  typedef enum logic
  {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_opcode_e;

  // Word 0 of program memory, word addressed
  localparam logic [ADDR_WIDTH-1:0] MEM_BASE_ADDR   = 28'h800_0000;

  localparam logic [ADDR_WIDTH-1:0] CFG_BASE_ADDR   = 28'h020_0000;
  localparam logic [ADDR_WIDTH-1:0] CFG_FREEZE_ADDR = 28'h030_0000;

  // Last table entry clears freeze, the rest write their own index
  function automatic logic [ADDR_WIDTH-1:0] cfg_entry_addr(input int unsigned idx,
                                                           input int unsigned count);
    if (idx == count - 1)
      return CFG_FREEZE_ADDR;
    else
      return CFG_BASE_ADDR + ADDR_WIDTH'(idx);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] cfg_entry_data(input int unsigned idx,
                                                           input int unsigned count);
    if (idx == count - 1)
      return '0;
    else
      return DATA_WIDTH'(idx);
  endfunction

endpackage

/* hdl/cfg_loader.sv */
// Configuration loader
`timescale 1ns/1ps

module cfg_loader
  import boot_pkg::*;
#(
  parameter int CFG_COUNT = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  output logic                  io_cmd_v_o,
  output logic [ADDR_WIDTH-1:0] io_cmd_addr_o,
  output logic [DATA_WIDTH-1:0] io_cmd_data_o,
  input  logic                  io_cmd_ready_i,

  input  logic                  io_resp_v_i,
  output logic                  io_resp_yumi_o,

  output logic                  cfg_done_o,
  output logic [31:0]           exec_cycle_o
);

  localparam int IDX_W = (CFG_COUNT > 1) ? $clog2(CFG_COUNT) : 1;

  logic [IDX_W-1:0] idx_r;
  logic             wait_r;
  logic             done_r;
  logic [31:0]      exec_cycle_r;

  // One command in flight at a time
  assign io_cmd_v_o     = ~reset_i & ~done_r & ~wait_r;
  assign io_cmd_addr_o  = cfg_entry_addr(idx_r, CFG_COUNT);
  assign io_cmd_data_o  = cfg_entry_data(idx_r, CFG_COUNT);
  assign io_resp_yumi_o = io_resp_v_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      idx_r  <= '0;
      wait_r <= 1'b0;
      done_r <= 1'b0;
    end
    else if (io_resp_yumi_o)
    begin
      wait_r <= 1'b0;
      if (idx_r == IDX_W'(CFG_COUNT - 1))
        done_r <= 1'b1;
      else
        idx_r <= idx_r + 1'b1;
    end
    else if (io_cmd_v_o && io_cmd_ready_i)
    begin
      wait_r <= 1'b1;
    end
  end

  // Execution counter held clear until the table is written
  always_ff @(posedge clk_i)
  begin
    if (reset_i || !done_r)
      exec_cycle_r <= '0;
    else
      exec_cycle_r <= exec_cycle_r + 32'd1;
  end

  assign cfg_done_o   = done_r;
  assign exec_cycle_o = exec_cycle_r;

  // Responses only come back for an issued command
  a_resp_needs_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    io_resp_v_i |-> wait_r)
  else
    $error("cfg_loader: I/O response with no command outstanding");

endmodule

/* hdl/prog_loader.sv */
// Program stream loader
`timescale 1ns/1ps

module prog_loader
  import boot_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  cfg_done_i,

  input  logic                  prog_v_i,
  input  logic [DATA_WIDTH-1:0] prog_data_i,
  input  logic                  prog_last_i,
  output logic                  prog_ready_o,

  output logic                  mem_cmd_v_o,
  output logic [ADDR_WIDTH-1:0] mem_cmd_addr_o,
  output logic [DATA_WIDTH-1:0] mem_cmd_data_o,
  input  logic                  mem_cmd_ready_i,

  input  logic                  mem_resp_v_i,
  output logic                  mem_resp_yumi_o,

  output logic                  prog_done_o
);

  // Room for far more writes than the memory queue holds
  localparam int CNT_W = 8;

  logic [ADDR_WIDTH-1:0] addr_r;
  logic [CNT_W-1:0]      pending_r;
  logic [CNT_W-1:0]      pending_n;
  logic                  sent_last_r;
  logic                  done_r;
  logic                  active;
  logic                  fire;

  assign active = cfg_done_i & ~sent_last_r;

  assign prog_ready_o   = active & mem_cmd_ready_i;
  assign mem_cmd_v_o    = active & prog_v_i;
  assign mem_cmd_addr_o = addr_r;
  assign mem_cmd_data_o = prog_data_i;
  assign fire           = mem_cmd_v_o & mem_cmd_ready_i;

  // Write acks carry nothing useful
  assign mem_resp_yumi_o = mem_resp_v_i;

  assign pending_n = pending_r + CNT_W'(fire) - CNT_W'(mem_resp_yumi_o);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      addr_r      <= MEM_BASE_ADDR;
      pending_r   <= '0;
      sent_last_r <= 1'b0;
      done_r      <= 1'b0;
    end
    else
    begin
      pending_r <= pending_n;
      if (fire)
      begin
        addr_r <= addr_r + 1'b1;
        if (prog_last_i)
          sent_last_r <= 1'b1;
      end
      if (sent_last_r && pending_n == '0)
        done_r <= 1'b1;
    end
  end

  assign prog_done_o = done_r;

  // Stream stays quiet between the last word and done
  a_no_word_after_last: assert property (@(posedge clk_i) disable iff (reset_i)
    (fire && prog_last_i) |=> (!prog_v_i throughout prog_done_o[->1]))
  else
    $error("prog_loader: stream word offered after the last one");

endmodule

/* hdl/mem_port_mux.sv */
// Memory port ownership mux
`timescale 1ns/1ps

module mem_port_mux
  import boot_pkg::*;
(
  input  logic                  prog_done_i,

  input  logic                  ld_cmd_v_i,
  input  logic [ADDR_WIDTH-1:0] ld_cmd_addr_i,
  input  logic [DATA_WIDTH-1:0] ld_cmd_data_i,
  output logic                  ld_cmd_ready_o,
  output logic                  ld_resp_v_o,
  input  logic                  ld_resp_yumi_i,

  input  logic                  proc_mem_cmd_v_i,
  input  mem_opcode_e           proc_mem_cmd_op_i,
  input  logic [ADDR_WIDTH-1:0] proc_mem_cmd_addr_i,
  input  logic [DATA_WIDTH-1:0] proc_mem_cmd_data_i,
  output logic                  proc_mem_cmd_ready_o,
  output logic                  proc_mem_resp_v_o,
  output logic [DATA_WIDTH-1:0] proc_mem_resp_data_o,
  input  logic                  proc_mem_resp_yumi_i,

  output logic                  mem_cmd_v_o,
  output mem_opcode_e           mem_cmd_op_o,
  output logic [ADDR_WIDTH-1:0] mem_cmd_addr_o,
  output logic [DATA_WIDTH-1:0] mem_cmd_data_o,
  input  logic                  mem_cmd_ready_i,
  input  logic                  mem_resp_v_i,
  input  logic [DATA_WIDTH-1:0] mem_resp_data_i,
  output logic                  mem_resp_yumi_o
);

  // Processor side stalls until the program is in memory
  assign mem_cmd_v_o    = prog_done_i ? proc_mem_cmd_v_i    : ld_cmd_v_i;
  assign mem_cmd_op_o   = prog_done_i ? proc_mem_cmd_op_i   : MEM_WRITE;
  assign mem_cmd_addr_o = prog_done_i ? proc_mem_cmd_addr_i : ld_cmd_addr_i;
  assign mem_cmd_data_o = prog_done_i ? proc_mem_cmd_data_i : ld_cmd_data_i;

  assign ld_cmd_ready_o       = ~prog_done_i & mem_cmd_ready_i;
  assign proc_mem_cmd_ready_o =  prog_done_i & mem_cmd_ready_i;

  assign ld_resp_v_o          = ~prog_done_i & mem_resp_v_i;
  assign proc_mem_resp_v_o    =  prog_done_i & mem_resp_v_i;
  assign proc_mem_resp_data_o = mem_resp_data_i;

  assign mem_resp_yumi_o = prog_done_i ? proc_mem_resp_yumi_i : ld_resp_yumi_i;

  // Last loader ack is drained in the cycle before handoff
  a_clean_handoff: assert property (@(posedge prog_done_i)
    !mem_resp_v_i || mem_resp_yumi_o)
  else
    $error("mem_port_mux: memory response pending at ownership change");

endmodule

/* hdl/mem_model.sv */
// Fixed latency memory model
`timescale 1ns/1ps

module mem_model
  import boot_pkg::*;
#(
  parameter int MEM_WORDS   = 1024,
  parameter int MEM_LATENCY = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  cmd_v_i,
  input  mem_opcode_e           cmd_op_i,
  input  logic [ADDR_WIDTH-1:0] cmd_addr_i,
  input  logic [DATA_WIDTH-1:0] cmd_data_i,
  output logic                  cmd_ready_o,

  output logic                  resp_v_o,
  output logic [DATA_WIDTH-1:0] resp_data_o,
  input  logic                  resp_yumi_i
);

  // Queue write adds the final cycle of latency
  localparam int PIPE_DEPTH  = MEM_LATENCY - 1;
  localparam int QUEUE_DEPTH = MEM_LATENCY + 2;
  localparam int IDX_W       = $clog2(MEM_WORDS);
  localparam int PTR_W       = $clog2(QUEUE_DEPTH);
  localparam int OCC_W       = $clog2(QUEUE_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem_r [MEM_WORDS];
  logic [ADDR_WIDTH-1:0] offset;
  logic [IDX_W-1:0]      word_idx;
  logic [DATA_WIDTH-1:0] rd_word;
  logic                  accept;
  logic                  push;
  logic                  pop;

  logic [PIPE_DEPTH-1:0] pipe_v_r;
  logic [DATA_WIDTH-1:0] pipe_data_r [PIPE_DEPTH];

  logic [DATA_WIDTH-1:0] q_data_r [QUEUE_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_r;
  logic [PTR_W-1:0]      rd_ptr_r;
  logic [OCC_W-1:0]      q_cnt_r;
  logic [OCC_W-1:0]      occ_r;

  assign offset   = cmd_addr_i - MEM_BASE_ADDR;
  assign word_idx = offset[IDX_W-1:0];
  assign accept   = cmd_v_i & cmd_ready_o;
  assign push     = pipe_v_r[PIPE_DEPTH-1];
  assign pop      = resp_v_o & resp_yumi_i;

  // Reads see memory before this cycle's write
  assign rd_word = (cmd_op_i == MEM_READ) ? mem_r[word_idx] : '0;

  always_ff @(posedge clk_i)
  begin
    if (accept && cmd_op_i == MEM_WRITE)
      mem_r[word_idx] <= cmd_data_i;
    pipe_data_r[0] <= rd_word;
    for (int k = 1; k < PIPE_DEPTH; k++)
      pipe_data_r[k] <= pipe_data_r[k-1];
    if (push)
      q_data_r[wr_ptr_r] <= pipe_data_r[PIPE_DEPTH-1];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pipe_v_r <= '0;
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      q_cnt_r  <= '0;
      occ_r    <= '0;
    end
    else
    begin
      pipe_v_r[0] <= accept;
      for (int k = 1; k < PIPE_DEPTH; k++)
        pipe_v_r[k] <= pipe_v_r[k-1];
      if (push)
        wr_ptr_r <= (wr_ptr_r == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      q_cnt_r <= q_cnt_r + OCC_W'(push) - OCC_W'(pop);
      // Queued plus in flight
      occ_r   <= occ_r + OCC_W'(accept) - OCC_W'(pop);
    end
  end

  assign cmd_ready_o = (occ_r < OCC_W'(QUEUE_DEPTH));
  assign resp_v_o    = (q_cnt_r != '0);
  assign resp_data_o = q_data_r[rd_ptr_r];

  a_addr_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> (offset < ADDR_WIDTH'(MEM_WORDS)))
  else
    $error("mem_model: address %h outside memory", cmd_addr_i);

endmodule

/* hdl/boot_mem_top.sv */
// Boot memory subsystem top
`timescale 1ns/1ps

module boot_mem_top
  import boot_pkg::*;
#(
  parameter int CFG_COUNT   = 8,
  parameter int MEM_WORDS   = 1024,
  parameter int MEM_LATENCY = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  output logic                  io_cmd_v_o,
  output logic [ADDR_WIDTH-1:0] io_cmd_addr_o,
  output logic [DATA_WIDTH-1:0] io_cmd_data_o,
  input  logic                  io_cmd_ready_i,
  input  logic                  io_resp_v_i,
  output logic                  io_resp_yumi_o,

  input  logic                  prog_v_i,
  input  logic [DATA_WIDTH-1:0] prog_data_i,
  input  logic                  prog_last_i,
  output logic                  prog_ready_o,

  input  logic                  proc_mem_cmd_v_i,
  input  mem_opcode_e           proc_mem_cmd_op_i,
  input  logic [ADDR_WIDTH-1:0] proc_mem_cmd_addr_i,
  input  logic [DATA_WIDTH-1:0] proc_mem_cmd_data_i,
  output logic                  proc_mem_cmd_ready_o,
  output logic                  proc_mem_resp_v_o,
  output logic [DATA_WIDTH-1:0] proc_mem_resp_data_o,
  input  logic                  proc_mem_resp_yumi_i,

  output logic                  cfg_done_o,
  output logic                  prog_done_o,
  output logic [31:0]           exec_cycle_o
);

  // Loader to mux
  logic                  ld_cmd_v_lo;
  logic [ADDR_WIDTH-1:0] ld_cmd_addr_lo;
  logic [DATA_WIDTH-1:0] ld_cmd_data_lo;
  logic                  ld_cmd_ready_li;
  logic                  ld_resp_v_li;
  logic                  ld_resp_yumi_lo;

  // Mux to memory
  logic                  mem_cmd_v_lo;
  mem_opcode_e           mem_cmd_op_lo;
  logic [ADDR_WIDTH-1:0] mem_cmd_addr_lo;
  logic [DATA_WIDTH-1:0] mem_cmd_data_lo;
  logic                  mem_cmd_ready_li;
  logic                  mem_resp_v_li;
  logic [DATA_WIDTH-1:0] mem_resp_data_li;
  logic                  mem_resp_yumi_lo;

  cfg_loader #(
    .CFG_COUNT(CFG_COUNT)
  ) i_cfg_loader (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .io_cmd_v_o     (io_cmd_v_o),
    .io_cmd_addr_o  (io_cmd_addr_o),
    .io_cmd_data_o  (io_cmd_data_o),
    .io_cmd_ready_i (io_cmd_ready_i),
    .io_resp_v_i    (io_resp_v_i),
    .io_resp_yumi_o (io_resp_yumi_o),
    .cfg_done_o     (cfg_done_o),
    .exec_cycle_o   (exec_cycle_o)
  );

  prog_loader i_prog_loader (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cfg_done_i      (cfg_done_o),
    .prog_v_i        (prog_v_i),
    .prog_data_i     (prog_data_i),
    .prog_last_i     (prog_last_i),
    .prog_ready_o    (prog_ready_o),
    .mem_cmd_v_o     (ld_cmd_v_lo),
    .mem_cmd_addr_o  (ld_cmd_addr_lo),
    .mem_cmd_data_o  (ld_cmd_data_lo),
    .mem_cmd_ready_i (ld_cmd_ready_li),
    .mem_resp_v_i    (ld_resp_v_li),
    .mem_resp_yumi_o (ld_resp_yumi_lo),
    .prog_done_o     (prog_done_o)
  );

  mem_port_mux i_mem_port_mux (
    .prog_done_i          (prog_done_o),
    .ld_cmd_v_i           (ld_cmd_v_lo),
    .ld_cmd_addr_i        (ld_cmd_addr_lo),
    .ld_cmd_data_i        (ld_cmd_data_lo),
    .ld_cmd_ready_o       (ld_cmd_ready_li),
    .ld_resp_v_o          (ld_resp_v_li),
    .ld_resp_yumi_i       (ld_resp_yumi_lo),
    .proc_mem_cmd_v_i     (proc_mem_cmd_v_i),
    .proc_mem_cmd_op_i    (proc_mem_cmd_op_i),
    .proc_mem_cmd_addr_i  (proc_mem_cmd_addr_i),
    .proc_mem_cmd_data_i  (proc_mem_cmd_data_i),
    .proc_mem_cmd_ready_o (proc_mem_cmd_ready_o),
    .proc_mem_resp_v_o    (proc_mem_resp_v_o),
    .proc_mem_resp_data_o (proc_mem_resp_data_o),
    .proc_mem_resp_yumi_i (proc_mem_resp_yumi_i),
    .mem_cmd_v_o          (mem_cmd_v_lo),
    .mem_cmd_op_o         (mem_cmd_op_lo),
    .mem_cmd_addr_o       (mem_cmd_addr_lo),
    .mem_cmd_data_o       (mem_cmd_data_lo),
    .mem_cmd_ready_i      (mem_cmd_ready_li),
    .mem_resp_v_i         (mem_resp_v_li),
    .mem_resp_data_i      (mem_resp_data_li),
    .mem_resp_yumi_o      (mem_resp_yumi_lo)
  );

  mem_model #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) i_mem_model (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_v_i     (mem_cmd_v_lo),
    .cmd_op_i    (mem_cmd_op_lo),
    .cmd_addr_i  (mem_cmd_addr_lo),
    .cmd_data_i  (mem_cmd_data_lo),
    .cmd_ready_o (mem_cmd_ready_li),
    .resp_v_o    (mem_resp_v_li),
    .resp_data_o (mem_resp_data_li),
    .resp_yumi_i (mem_resp_yumi_lo)
  );

endmodule

/* verif/tb_boot_mem.sv */
// Boot memory testbench
`timescale 1ns/1ps

module tb_boot_mem
  import boot_pkg::*;
();

  localparam int CFG_COUNT   = 8;
  localparam int MEM_WORDS   = 1024;
  localparam int MEM_LATENCY = 4;
  localparam int PROG_WORDS  = 32;
  localparam int TIMEOUT     = 1000;

  logic                  clk_i;
  logic                  reset_i = 1'b1;
  logic                  io_cmd_v_o;
  logic [ADDR_WIDTH-1:0] io_cmd_addr_o;
  logic [DATA_WIDTH-1:0] io_cmd_data_o;
  logic                  io_cmd_ready_i = 1'b0;
  logic                  io_resp_v_i = 1'b0;
  logic                  io_resp_yumi_o;
  logic                  prog_v_i = 1'b0;
  logic [DATA_WIDTH-1:0] prog_data_i = '0;
  logic                  prog_last_i = 1'b0;
  logic                  prog_ready_o;
  logic                  proc_mem_cmd_v_i = 1'b0;
  mem_opcode_e           proc_mem_cmd_op_i = MEM_READ;
  logic [ADDR_WIDTH-1:0] proc_mem_cmd_addr_i = '0;
  logic [DATA_WIDTH-1:0] proc_mem_cmd_data_i = '0;
  logic                  proc_mem_cmd_ready_o;
  logic                  proc_mem_resp_v_o;
  logic [DATA_WIDTH-1:0] proc_mem_resp_data_o;
  logic                  proc_mem_resp_yumi_i = 1'b0;
  logic                  cfg_done_o;
  logic                  prog_done_o;
  logic [31:0]           exec_cycle_o;

  integer                seed = 27;
  integer                resp_seed = 27;
  logic [DATA_WIDTH-1:0] mirror [PROG_WORDS];
  logic [DATA_WIDTH-1:0] exp_q [$];
  logic [DATA_WIDTH-1:0] exp_data;
  logic                  prev_cfg_done = 1'b0;
  logic [31:0]           prev_exec = '0;

  boot_mem_top #(
    .CFG_COUNT   (CFG_COUNT),
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) i_dut (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .io_cmd_v_o           (io_cmd_v_o),
    .io_cmd_addr_o        (io_cmd_addr_o),
    .io_cmd_data_o        (io_cmd_data_o),
    .io_cmd_ready_i       (io_cmd_ready_i),
    .io_resp_v_i          (io_resp_v_i),
    .io_resp_yumi_o       (io_resp_yumi_o),
    .prog_v_i             (prog_v_i),
    .prog_data_i          (prog_data_i),
    .prog_last_i          (prog_last_i),
    .prog_ready_o         (prog_ready_o),
    .proc_mem_cmd_v_i     (proc_mem_cmd_v_i),
    .proc_mem_cmd_op_i    (proc_mem_cmd_op_i),
    .proc_mem_cmd_addr_i  (proc_mem_cmd_addr_i),
    .proc_mem_cmd_data_i  (proc_mem_cmd_data_i),
    .proc_mem_cmd_ready_o (proc_mem_cmd_ready_o),
    .proc_mem_resp_v_o    (proc_mem_resp_v_o),
    .proc_mem_resp_data_o (proc_mem_resp_data_o),
    .proc_mem_resp_yumi_i (proc_mem_resp_yumi_i),
    .cfg_done_o           (cfg_done_o),
    .prog_done_o          (prog_done_o),
    .exec_cycle_o         (exec_cycle_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    $display("[ERROR] %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
    abort_run();
  endtask

  task automatic fail_text(input string msg);
    $display("%0d ns: %s", $time, msg);
    abort_run();
  endtask

  // Config table rule
  function automatic logic [ADDR_WIDTH-1:0] expected_cfg_addr(input int idx);
    if (idx == CFG_COUNT - 1)
      return CFG_FREEZE_ADDR;
    return CFG_BASE_ADDR + ADDR_WIDTH'(idx);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_cfg_data(input int idx);
    if (idx == CFG_COUNT - 1)
      return '0;
    return DATA_WIDTH'(idx);
  endfunction

  task automatic run_config();
    int n;
    int delay;
    for (int i = 0; i < CFG_COUNT; i++)
    begin
      n = 0;
      do
      begin
        io_cmd_ready_i <= ($random(seed) % 2 != 0);
        @(posedge clk_i);
        n++;
        if (n > TIMEOUT)
          fail_text("timed out waiting for a config command");
      end
      while (!(io_cmd_v_o && io_cmd_ready_i));
      assert (io_cmd_addr_o == expected_cfg_addr(i))
      else
        fail_value("io_cmd_addr_o", expected_cfg_addr(i), io_cmd_addr_o);
      assert (io_cmd_data_o == expected_cfg_data(i))
      else
        fail_value("io_cmd_data_o", expected_cfg_data(i), io_cmd_data_o);
      assert (!cfg_done_o)
      else
        fail_text("cfg_done_o high before the table was finished");
      io_cmd_ready_i <= 1'b0;
      delay = $unsigned($random(seed)) % 5;
      n = 0;
      do
      begin
        io_resp_v_i <= (n >= delay);
        @(posedge clk_i);
        n++;
        assert (!io_cmd_v_o)
        else
          fail_text("next config command issued before the response");
        if (n > TIMEOUT)
          fail_text("timed out waiting for the config response to be consumed");
      end
      while (!(io_resp_v_i && io_resp_yumi_o));
      io_resp_v_i <= 1'b0;
    end
    @(posedge clk_i);
    assert (cfg_done_o)
    else
      fail_text("cfg_done_o did not rise after the last response");
  endtask

  task automatic load_program();
    int n;
    int gap;
    for (int i = 0; i < PROG_WORDS; i++)
    begin
      mirror[i] = {$random(seed), $random(seed)};
      gap = $unsigned($random(seed)) % 4;
      prog_v_i <= 1'b0;
      repeat (gap) @(posedge clk_i);
      prog_v_i    <= 1'b1;
      prog_data_i <= mirror[i];
      prog_last_i <= (i == PROG_WORDS - 1);
      n = 0;
      do
      begin
        @(posedge clk_i);
        n++;
        if (n > TIMEOUT)
          fail_text("timed out waiting for a program word to be accepted");
      end
      while (!(prog_v_i && prog_ready_o));
    end
    prog_v_i    <= 1'b0;
    prog_last_i <= 1'b0;
    n = 0;
    while (!prog_done_o)
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        fail_text("timed out waiting for prog_done_o");
    end
  endtask

  task automatic issue_cmd(input mem_opcode_e op, input int idx,
                           input logic [63:0] data, input logic [63:0] expected);
    int n;
    proc_mem_cmd_v_i    <= 1'b1;
    proc_mem_cmd_op_i   <= op;
    proc_mem_cmd_addr_i <= MEM_BASE_ADDR + ADDR_WIDTH'(idx);
    proc_mem_cmd_data_i <= data;
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        fail_text("timed out waiting for the processor command to be accepted");
    end
    while (!(proc_mem_cmd_v_i && proc_mem_cmd_ready_o));
    exp_q.push_back(expected);
  endtask

  // Sampled on the falling edge, clear of the response process
  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0)
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT)
        fail_text("timed out waiting for processor responses");
    end
    @(posedge clk_i);
  endtask

  task automatic write_then_read();
    int n;
    int idx;
    logic [63:0] data;
    for (int k = 0; k < 8; k++)
    begin
      idx  = $unsigned($random(seed)) % PROG_WORDS;
      data = {$random(seed), $random(seed)};
      issue_cmd(MEM_WRITE, idx, data, '0);
      mirror[idx] = data;
      proc_mem_cmd_v_i <= 1'b0;
      wait_drained();
      issue_cmd(MEM_READ, idx, '0, mirror[idx]);
      proc_mem_cmd_v_i <= 1'b0;
      n = 0;
      do
      begin
        @(posedge clk_i);
        n++;
        if (n > TIMEOUT)
          fail_text("timed out waiting for a read response");
      end
      while (!proc_mem_resp_v_o);
      assert (n == MEM_LATENCY)
      else
        fail_value("proc_mem_resp_v_o latency", MEM_LATENCY, n);
      wait_drained();
    end
  endtask

  // Response side: compare in order, randomly hold off yumi
  always @(posedge clk_i)
  begin
    if (reset_i)
      proc_mem_resp_yumi_i <= 1'b0;
    else
    begin
      if (proc_mem_resp_v_o && proc_mem_resp_yumi_i)
      begin
        if (exp_q.size() == 0)
          fail_text("processor response with nothing outstanding");
        exp_data = exp_q.pop_front();
        assert (proc_mem_resp_data_o == exp_data)
        else
          fail_value("proc_mem_resp_data_o", exp_data, proc_mem_resp_data_o);
      end
      // Skip a cycle after each consume, valid may drop then
      proc_mem_resp_yumi_i <= proc_mem_resp_v_o && !proc_mem_resp_yumi_i
                              && ($random(resp_seed) % 3 != 0);
    end
  end

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (!cfg_done_o)
        assert (exec_cycle_o == 32'd0)
        else
          fail_value("exec_cycle_o", 0, exec_cycle_o);
      else if (prev_cfg_done)
        assert (exec_cycle_o == prev_exec + 32'd1)
        else
          fail_value("exec_cycle_o", prev_exec + 32'd1, exec_cycle_o);
      if (!prog_done_o)
        assert (!proc_mem_cmd_ready_o && !proc_mem_resp_v_o)
        else
          fail_text("processor port active before the program was loaded");
      prev_cfg_done = cfg_done_o;
      prev_exec     = exec_cycle_o;
    end
  end

  initial
  begin
    repeat (8) @(posedge clk_i);
    assert (!cfg_done_o && !prog_done_o && !prog_ready_o && !io_cmd_v_o
            && !proc_mem_cmd_ready_o && !proc_mem_resp_v_o)
    else
      fail_text("control output high during reset");
    assert (exec_cycle_o == 32'd0)
    else
      fail_value("exec_cycle_o", 0, exec_cycle_o);
    reset_i <= 1'b0;
    run_config();
    load_program();
    for (int i = 0; i < PROG_WORDS; i++)
      issue_cmd(MEM_READ, i, '0, mirror[i]);
    proc_mem_cmd_v_i <= 1'b0;
    wait_drained();
    write_then_read();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* files.f */
hdl/boot_pkg.sv
hdl/cfg_loader.sv
hdl/prog_loader.sv
hdl/mem_port_mux.sv
hdl/mem_model.sv
hdl/boot_mem_top.sv
verif/tb_boot_mem.sv
